// File: booth_mult_config.svh
`ifndef BOOTH_MULT_CONFIG_SVH
`define BOOTH_MULT_CONFIG_SVH

`default_nettype none

// Operand width in bits, the design works from 4 to 32
`define BOOTH_WIDTH 8

// Counter must hold BOOTH_WIDTH itself, since it advances on the last step
`define BOOTH_CNT_WIDTH ($clog2(`BOOTH_WIDTH) + 1)

`default_nettype wire

`endif

// File: booth_mult_pkg.sv
`include "booth_mult_config.svh"

`default_nettype none

package booth_mult_pkg;

    typedef logic signed [`BOOTH_WIDTH-1:0]   operand_t;    // One signed operand
    typedef logic signed [2*`BOOTH_WIDTH-1:0] product_t;    // Full signed product
    typedef logic [`BOOTH_CNT_WIDTH-1:0]      step_count_t; // Booth step index
    typedef logic [1:0]                       booth_op_t;   // Op select / bit pair

    // Op select codes, 2'b11 also means hold
    localparam booth_op_t OP_HOLD = 2'b00;
    localparam booth_op_t OP_ADD  = 2'b01;
    localparam booth_op_t OP_SUB  = 2'b10;

    typedef struct packed {
        operand_t multiplicand;
        operand_t multiplier;
    } mult_req_t;

    typedef enum logic [1:0] {
        IDLE = 2'b00, // Waiting for an operand pair
        RUN  = 2'b01, // One Booth step per cycle
        DONE = 2'b10  // Product offered on dest side
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: booth_step_counter.sv
`timescale 1ns/1ns
`include "booth_mult_config.svh"
`default_nettype none

module booth_step_counter
    import booth_mult_pkg::*;
(
    input  wire  clk,
    input  wire  rst,
    input  wire  clear,
    input  wire  step,
    output logic last_step
);

    step_count_t count;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            count <= '0;
        end
        else if (clear)
        begin
            count <= '0; // New operation
        end
        else if (step)
        begin
            count <= count + step_count_t'(1);
        end
    end

    // High during the final RUN cycle
    assign last_step = (count == step_count_t'(`BOOTH_WIDTH - 1));

endmodule

`default_nettype wire

// File: booth_controller.sv
`timescale 1ns/1ns
`default_nettype none

module booth_controller
    import booth_mult_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire            src_valid,
    input  wire            dest_ready,
    input  wire booth_op_t booth_pair,
    input  wire            last_step,
    output logic           src_ready,
    output logic           dest_valid,
    output logic           load,
    output logic           clear,
    output logic           step,
    output booth_op_t      op_sel
);

    ctrl_state_t state;
    ctrl_state_t next_state;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        src_ready  = 1'b0;
        dest_valid = 1'b0;
        load       = 1'b0;
        clear      = 1'b0;
        step       = 1'b0;
        op_sel     = OP_HOLD;
        case (state)
            IDLE:
            begin
                src_ready = 1'b1;
                if (src_valid)
                begin
                    load       = 1'b1; // Capture the operand pair
                    clear      = 1'b1; // Restart the step count
                    next_state = RUN;
                end
            end
            RUN:
            begin
                step = 1'b1;
                // Recode {Q0, Q-1} into the accumulator operation
                case (booth_pair)
                    2'b01:   op_sel = OP_ADD;
                    2'b10:   op_sel = OP_SUB;
                    default: op_sel = OP_HOLD; // 00 and 11
                endcase
                if (last_step)
                begin
                    next_state = DONE;
                end
            end
            DONE:
            begin
                dest_valid = 1'b1; // Product is final here
                if (dest_ready)
                begin
                    next_state = IDLE;
                end
            end
            default:
            begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: booth_datapath.sv
`timescale 1ns/1ns
`include "booth_mult_config.svh"
`default_nettype none

module booth_datapath
    import booth_mult_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire            load,
    input  wire            step,
    input  wire booth_op_t op_sel,
    input  wire mult_req_t req,
    output booth_op_t      booth_pair,
    output product_t       product
);

    localparam int W = `BOOTH_WIDTH;

    operand_t multiplicand;
    operand_t acc;     // Upper half of the running product
    operand_t mult_q;  // Multiplier, shifts into the lower half
    logic     q_extra; // Q-1 bit

    logic signed [W:0]     acc_ext;
    logic signed [W:0]     mcand_ext;
    logic signed [W:0]     sum;
    logic signed [2*W+1:0] shifted;

    // One extra bit so an add or subtract cannot lose the sign
    assign acc_ext   = {acc[W-1], acc};
    assign mcand_ext = {multiplicand[W-1], multiplicand};

    always_comb
    begin
        case (op_sel)
            OP_ADD:  sum = acc_ext + mcand_ext;
            OP_SUB:  sum = acc_ext - mcand_ext;
            default: sum = acc_ext;
        endcase
    end

    // Sum, multiplier and Q-1 shift together as one value
    assign shifted = $signed({sum, mult_q, q_extra}) >>> 1;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            multiplicand <= '0;
            acc          <= '0;
            mult_q       <= '0;
            q_extra      <= 1'b0;
        end
        else if (load)
        begin
            multiplicand <= req.multiplicand;
            acc          <= '0;
            mult_q       <= req.multiplier;
            q_extra      <= 1'b0;
        end
        else if (step)
        begin
            acc     <= shifted[2*W:W+1];
            mult_q  <= shifted[W:1];
            q_extra <= shifted[0]; // Old Q0 becomes Q-1
        end
    end

    assign booth_pair = {mult_q[0], q_extra};
    assign product    = {acc, mult_q};

endmodule

`default_nettype wire

// File: booth_mult.sv
`timescale 1ns/1ns
`default_nettype none

module booth_mult
    import booth_mult_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire            src_valid,
    input  wire mult_req_t src_data,
    input  wire            dest_ready,
    output logic           src_ready,
    output logic           dest_valid,
    output product_t       dest_data
);

    logic      load;
    logic      clear;
    logic      step;
    logic      last_step;
    booth_op_t op_sel;
    booth_op_t booth_pair;

    booth_controller u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .src_valid  (src_valid),
        .dest_ready (dest_ready),
        .booth_pair (booth_pair),
        .last_step  (last_step),
        .src_ready  (src_ready),
        .dest_valid (dest_valid),
        .load       (load),
        .clear      (clear),
        .step       (step),
        .op_sel     (op_sel)
    );

    booth_step_counter u_cnt (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .step      (step),
        .last_step (last_step)
    );

    booth_datapath u_dp (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .step       (step),
        .op_sel     (op_sel),
        .req        (src_data),
        .booth_pair (booth_pair),
        .product    (dest_data) // Held while DONE waits
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns = 20
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: booth_mult_props.sv
`timescale 1ns/1ns
`include "booth_mult_config.svh"
`default_nettype none

module booth_mult_props
    import booth_mult_pkg::*;
(
    input wire           clk,
    input wire           rst,
    input wire           src_valid,
    input wire           src_ready,
    input wire           dest_valid,
    input wire           dest_ready,
    input wire product_t dest_data
);

    // Only one side of the unit is open at a time
    property no_overlap;
        @(posedge clk) disable iff (!rst)
        !(dest_valid && src_ready);
    endproperty

    // A stalled result keeps its value
    property product_held;
        @(posedge clk) disable iff (!rst)
        (dest_valid && !dest_ready) |=> (dest_valid && $stable(dest_data));
    endproperty

    // First offer comes a fixed number of cycles after acceptance
    property fixed_latency;
        @(posedge clk) disable iff (!rst)
        (src_valid && src_ready) |-> ##(`BOOTH_WIDTH + 1) $rose(dest_valid);
    endproperty

    assert property (no_overlap)
        else $error("src_ready and dest_valid are high together");

    assert property (product_held)
        else $error("dest_data changed or dest_valid dropped while stalled");

    assert property (fixed_latency)
        else $error("dest_valid did not rise at the expected cycle after acceptance");

endmodule

bind booth_mult booth_mult_props u_props (
    .clk        (clk),
    .rst        (rst),
    .src_valid  (src_valid),
    .src_ready  (src_ready),
    .dest_valid (dest_valid),
    .dest_ready (dest_ready),
    .dest_data  (dest_data)
);

`default_nettype wire

// File: booth_mult_tb.sv
`timescale 1ns/1ns
`include "booth_mult_config.svh"
`default_nettype none

module booth_mult_tb
    import booth_mult_pkg::*;
;

    localparam int n_corner       = 12;
    localparam int n_random       = 200;
    localparam int n_backpressure = 20;
    localparam int n_busy         = 6;
    localparam int n_latency      = 4;
    localparam int n_reset        = 2;
    localparam int total_ops      = n_corner + n_random + n_backpressure + n_busy
                                    + n_latency + n_reset;
    localparam int watchdog_ns    = total_ops * (`BOOTH_WIDTH + 20) * 20 + 2000;

    logic      clk;
    logic      rst;
    logic      src_valid;
    mult_req_t src_data;
    logic      dest_ready;
    logic      src_ready;
    logic      dest_valid;
    product_t  dest_data;

    mult_req_t   expected[$]; // Accepted requests, oldest first
    mult_req_t   got_req;
    logic        hold_seen;
    product_t    held_data;
    logic [31:0] rng_state = 32'h894c;
    string       cur_test  = "reset";
    int          error_count;
    int          check_count;
    int          test_start_errors;
    int          tests_run;
    int          failed_tests;

    tb_clock_gen #(.period_ns(20)) u_clk (.clk(clk));

    booth_mult uut (
        .clk        (clk),
        .rst        (rst),
        .src_valid  (src_valid),
        .src_data   (src_data),
        .dest_ready (dest_ready),
        .src_ready  (src_ready),
        .dest_valid (dest_valid),
        .dest_data  (dest_data)
    );

    // Plain signed multiply, both operands widened first
    function automatic product_t ref_product(operand_t a, operand_t b);
        product_t wide_a;
        product_t wide_b;
        wide_a = product_t'(a);
        wide_b = product_t'(b);
        return wide_a * wide_b;
    endfunction

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic mult_req_t make_req(operand_t mcand, operand_t mplier);
        mult_req_t req;
        req.multiplicand = mcand;
        req.multiplier   = mplier;
        return req;
    endfunction

    task automatic next_rand(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value     = rng_state;
    endtask

    task automatic rand_req(output mult_req_t req);
        logic [31:0] r;
        next_rand(r);
        req.multiplicand = operand_t'(r);
        next_rand(r);
        req.multiplier = operand_t'(r);
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR in %s: %s", cur_test, msg);
    endtask

    task automatic check_product(input string name, input product_t exp, input product_t act);
        check_count++;
        if (act !== exp)
        begin
            error_count++;
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp)
        begin
            error_count++;
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        check_count++;
        if (act != exp)
        begin
            error_count++;
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test          = name;
        test_start_errors = error_count;
    endtask

    task automatic end_test();
        repeat (2) @(posedge clk); // Let the last result drain
        if (expected.size() != 0)
        begin
            report_error("an accepted request never produced a result");
        end
        tests_run++;
        if (error_count == test_start_errors)
        begin
            $display("Test %s passed", cur_test);
        end
        else
        begin
            failed_tests++;
            $display("Test %s failed with %0d errors", cur_test,
                     error_count - test_start_errors);
        end
    endtask

    // Offer one pair and return on its acceptance edge
    task automatic send_op(input mult_req_t req, input logic keep_valid);
        logic taken;
        taken = 1'b0;
        @(posedge clk);
        src_valid <= 1'b1;
        src_data  <= req;
        while (!taken)
        begin
            @(posedge clk);
            taken = src_valid && src_ready;
        end
        if (!keep_valid)
        begin
            src_valid <= 1'b0;
        end
    endtask

    // Wait for the result, stall it for hold cycles, optionally keep offering noise
    task automatic finish_op(input int hold, input logic scramble);
        int        held;
        logic      done;
        mult_req_t noise;
        held = 0;
        done = 1'b0;
        if (hold > 0)
        begin
            dest_ready <= 1'b0;
        end
        while (!done)
        begin
            @(posedge clk);
            if (scramble)
            begin
                check_flag({cur_test, " src_ready while busy"}, 1'b0, src_ready);
            end
            if (dest_valid && dest_ready)
            begin
                done = 1'b1;
            end
            else
            begin
                if (dest_valid)
                begin
                    held++;
                    if (held >= hold)
                    begin
                        dest_ready <= 1'b1;
                    end
                end
                if (scramble)
                begin
                    rand_req(noise);
                    src_data <= noise; // Must be ignored outside IDLE
                end
            end
        end
        src_valid <= 1'b0;
    endtask

    task automatic run_op(input mult_req_t req, input int hold);
        send_op(req, 1'b0);
        finish_op(hold, 1'b0);
    endtask

    task automatic corner_products();
        mult_req_t pairs[n_corner];
        operand_t  min_val;
        operand_t  max_val;
        operand_t  alt;
        min_val          = '0;
        min_val[`BOOTH_WIDTH-1] = 1'b1;
        max_val          = ~min_val;
        for (int i = 0; i < `BOOTH_WIDTH; i++)
        begin
            alt[i] = i[0]; // 1010... pattern
        end
        begin_test("corner_products");
        pairs[0]  = make_req('0, '0);
        pairs[1]  = make_req('0, min_val);
        pairs[2]  = make_req(operand_t'(1), operand_t'(1));
        pairs[3]  = make_req(operand_t'(1), '1);
        pairs[4]  = make_req('1, '1);
        pairs[5]  = make_req(min_val, min_val);
        pairs[6]  = make_req(min_val, max_val);
        pairs[7]  = make_req(max_val, min_val);
        pairs[8]  = make_req(max_val, max_val);
        pairs[9]  = make_req(alt, ~alt);
        pairs[10] = make_req(~alt, alt);
        pairs[11] = make_req('1, min_val);
        for (int i = 0; i < n_corner; i++)
        begin
            run_op(pairs[i], 0);
        end
        end_test();
    endtask

    task automatic random_products();
        mult_req_t req;
        begin_test("random_products");
        for (int i = 0; i < n_random; i++)
        begin
            rand_req(req);
            run_op(req, 0);
        end
        end_test();
    endtask

    task automatic stall_results();
        mult_req_t   req;
        logic [31:0] r;
        begin_test("backpressure");
        for (int i = 0; i < n_backpressure; i++)
        begin
            rand_req(req);
            next_rand(r);
            run_op(req, int'(r[3:0])); // 0 to 15 stalled cycles
        end
        end_test();
    endtask

    task automatic offer_while_busy();
        mult_req_t req;
        begin_test("busy_rejection");
        for (int i = 0; i < n_busy; i++)
        begin
            rand_req(req);
            send_op(req, 1'b1);
            finish_op(3, 1'b1);
        end
        end_test();
    endtask

    task automatic measure_latency();
        mult_req_t req;
        int        cycles;
        begin_test("latency");
        for (int i = 0; i < n_latency; i++)
        begin
            rand_req(req);
            send_op(req, 1'b0);
            cycles = 0;
            do
            begin
                @(posedge clk);
                cycles++;
            end
            while (!dest_valid);
            check_latency({cur_test, " cycles to dest_valid"}, `BOOTH_WIDTH + 1, cycles);
        end
        end_test();
    endtask

    task automatic reset_mid_run();
        mult_req_t req;
        begin_test("reset_mid_operation");
        rand_req(req);
        send_op(req, 1'b0);
        repeat (`BOOTH_WIDTH / 2) @(posedge clk);
        rst <= 1'b0; // Abort while in RUN
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        check_flag({cur_test, " dest_valid after reset"}, 1'b0, dest_valid);
        check_flag({cur_test, " src_ready after reset"}, 1'b1, src_ready);
        rand_req(req);
        run_op(req, 0);
        end_test();
    endtask

    // Compare process: tracks acceptances and checks every result in order
    always @(posedge clk)
    begin
        if (!rst)
        begin
            expected.delete(); // Aborted work yields no result
            hold_seen = 1'b0;
        end
        else
        begin
            if (hold_seen)
            begin
                check_flag({cur_test, " dest_valid held"}, 1'b1, dest_valid);
                check_product({cur_test, " product held"}, held_data, dest_data);
            end
            hold_seen = dest_valid && !dest_ready;
            held_data = dest_data;
            if (src_valid && src_ready)
            begin
                expected.push_back(src_data);
            end
            if (dest_valid && dest_ready)
            begin
                if (expected.size() == 0)
                begin
                    report_error("a result was offered with no accepted request");
                end
                else
                begin
                    got_req = expected.pop_front();
                    check_product(cur_test,
                                  ref_product(got_req.multiplicand, got_req.multiplier),
                                  dest_data);
                end
            end
        end
    end

    initial
    begin
        #(watchdog_ns);
        $display("Timeout: simulation still running after %0d ns", watchdog_ns);
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        rst        = 1'b0;
        src_valid  = 1'b0;
        src_data   = '0;
        dest_ready = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        corner_products();
        random_products();
        stall_results();
        offer_while_busy();
        measure_latency();
        reset_mid_run();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, failed_tests, check_count, error_count);
        if (error_count == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: booth_mult.f
+incdir+.
booth_mult_pkg.sv
booth_step_counter.sv
booth_controller.sv
booth_datapath.sv
booth_mult.sv
tb_clock_gen.sv
booth_mult_props.sv
booth_mult_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := booth_mult_tb
FILELIST  := booth_mult.f
OBJ_DIR   := obj_dir
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, look for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
